/* decoder_controller.f */
source/decoder_pkg.sv
source/stage_if.sv
source/stage_controller.sv
source/measurement_loader.sv
source/decode_counters.sv
source/correction_encoder.sv
source/decoder_controller.sv
tb/decoder_controller_sva.sv
tb/decoder_controller_tb.sv

/* Bender.yml */
package:
  name: decoder_controller

sources:
  - source/decoder_pkg.sv
  - source/stage_if.sv
  - source/stage_controller.sv
  - source/measurement_loader.sv
  - source/decode_counters.sv
  - source/correction_encoder.sv
  - source/decoder_controller.sv
  - target: test
    files:
      - tb/decoder_controller_sva.sv
      - tb/decoder_controller_tb.sv

/* tb/decoder_controller_tb.sv */
`timescale 1ns/10ps

module decoder_controller_tb;
    import decoder_pkg::*;

    localparam int case_count = 4;
    localparam int timeout_cycles = 500;
    localparam int drive_delay = 5;

    logic clk;
    logic reset;
    data_word_t input_data;
    logic input_valid;
    logic input_ready;
    data_word_t output_data;
    logic output_valid;
    logic output_ready;
    ctrl_word_t ctrl_rx_data;
    logic ctrl_rx_valid;
    logic ctrl_rx_ready;
    ctrl_word_t ctrl_tx_data;
    logic ctrl_tx_valid;
    pe_vector_t busy_pe;
    pe_vector_t odd_clusters_pe;
    measurement_t measurements;
    correction_t correction;
    stage_t global_stage;
    logic reset_all_edges;

    // rounds packed as {round 2, round 1, round 0}
    pe_vector_t defect_table [case_count] = '{
        {4'h9, 4'h0, 4'h3},
        {4'h0, 4'h0, 4'h0},
        {4'hf, 4'h6, 4'h0},
        {4'h1, 4'h8, 4'h2}
    };
    int odd_table [case_count] = '{2, 0, 1, 3};
    int busy_table [case_count] = '{6, 0, 2, 9};
    logic peel_table [case_count] = '{1'b1, 1'b0, 1'b1, 1'b0};
    logic [3*correction_count-1:0] corr_table [case_count] = '{
        {11'h401, 11'h000, 11'h0a5},
        {11'h000, 11'h7ff, 11'h000},
        {11'h300, 11'h010, 11'h001},
        {11'h555, 11'h000, 11'h002}
    };
    int iter_table [case_count] = '{3, 1, 2, 4};

    logic [31:0] rng;
    int cur;
    int load_index;
    int work_cycles;
    int msg_count;
    int out_index;
    int grows_seen;
    int merge_cycles;
    int merge_length;
    int result_index;
    logic active;
    logic saw_peel;
    logic word_taken;
    logic frame_done;
    data_word_t words [$];
    data_word_t expect_q [$];

    decoder_controller dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %s: got %h, expected %h",
                                        name, actual, expected));
        end
    endtask

    // input stream, PE array model and output back-pressure
    always @(posedge clk) begin
        #(drive_delay);
        rng = next_random(rng);
        output_ready = rng[0];
        if (word_taken) begin
            void'(words.pop_front());
            word_taken = 1'b0;
        end
        input_valid = active && (words.size() != 0);
        if (words.size() != 0) begin
            input_data = words[0];
        end else begin
            input_data = '0;
        end
        if (global_stage == stage_grow) begin
            grows_seen++;
        end
        if (global_stage == stage_merge) begin
            merge_cycles++;
        end else begin
            merge_cycles = 0;
        end
        busy_pe = (global_stage == stage_merge && merge_cycles <= busy_table[cur]) ? '1 : '0;
        if (grows_seen != 0 && grows_seen <= odd_table[cur]) begin
            odd_clusters_pe = pe_vector_t'(1) << grows_seen;
        end else begin
            odd_clusters_pe = '0;
        end
        if (global_stage == stage_result_valid) begin
            correction = corr_table[cur][correction_count*result_index +: correction_count];
            result_index++;
        end else begin
            correction = '0;
            result_index = 0;
        end
    end

    // checks on stable values between edges
    always @(negedge clk) begin
        if (!reset && active) begin
            if (global_stage == stage_measurement_loading) begin
                if (load_index >= grid_width_u) begin
                    stop_with_failure("more loading cycles than measurement rounds");
                end
                check_value("measurements", measurements,
                            defect_table[cur][pu_count_per_round*load_index +: pu_count_per_round]);
                check_value("reset_all_edges", reset_all_edges, 1'b1);
                load_index++;
            end
            if (global_stage inside {stage_grow, stage_merge, stage_peeling, stage_reset_roots}) begin
                work_cycles++;
            end
            // merge has to settle and then outlast the busy PEs
            if (global_stage == stage_merge) begin
                merge_length++;
            end else if (merge_length != 0) begin
                if (merge_length <= maximum_delay || merge_length <= busy_table[cur]) begin
                    stop_with_failure("merge stage ended too early while the PEs were busy");
                end
                merge_length = 0;
            end
            if (global_stage == stage_peeling) begin
                saw_peel = 1'b1;
            end
            if (ctrl_tx_valid) begin
                check_value("ctrl_tx_data header", ctrl_tx_data[msg_header_msb:msg_header_lsb],
                            header_result);
                check_value("ctrl_tx_data cycles", ctrl_tx_data[15:0], work_cycles + 1);
                msg_count++;
            end
            if (input_valid && input_ready) begin
                word_taken = 1'b1;
            end
            if (output_valid && output_ready) begin
                if (out_index == 0) begin
                    check_value("stats upper byte", output_data[31:24], 0);
                    check_value("stats iteration", output_data[23:16], iter_table[cur]);
                    check_value("stats cycles", output_data[15:0], work_cycles + 1);
                end else if (expect_q.size() == 0) begin
                    stop_with_failure("output word arrived after the end marker");
                end else begin
                    check_value("output_data", output_data, expect_q.pop_front());
                    if (expect_q.size() == 0) begin
                        frame_done = 1'b1;
                    end
                end
                out_index++;
            end
        end
    end

    task automatic run_case(input int c);
        int waited;
        words.delete();
        expect_q.delete();
        for (int r = 0; r < grid_width_u; r++) begin
            for (int x = 0; x < grid_width_x; x++) begin
                if (defect_table[c][pu_count_per_round*r + x]) begin
                    words.push_back(data_word_t'(r * 4 + x));
                end
            end
        end
        words.push_back(end_of_stream_word);
        for (int r = 0; r < grid_width_u; r++) begin
            for (int b = 0; b < correction_count; b++) begin
                if (corr_table[c][correction_count*r + b]) begin
                    expect_q.push_back(data_word_t'((r << 4) | b));
                end
            end
        end
        expect_q.push_back(end_of_stream_word);
        cur = c;
        load_index = 0;
        work_cycles = 0;
        msg_count = 0;
        out_index = 0;
        grows_seen = 0;
        merge_length = 0;
        saw_peel = 1'b0;
        word_taken = 1'b0;
        frame_done = 1'b0;
        active = 1'b1;
        @(posedge clk);
        #(drive_delay);
        check_value("ctrl_rx_ready", ctrl_rx_ready, 1'b1);
        ctrl_rx_data = '0;
        ctrl_rx_data[msg_header_msb:msg_header_lsb] = header_decode_block;
        ctrl_rx_data[0] = peel_table[c];
        ctrl_rx_valid = 1'b1;
        @(posedge clk);
        #(drive_delay);
        ctrl_rx_valid = 1'b0;
        check_value("global_stage", global_stage, stage_measurement_preparing);
        waited = 0;
        while (!frame_done) begin
            @(posedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                stop_with_failure("timeout while waiting for the end of the output frame");
            end
        end
        check_value("loading cycles", load_index, grid_width_u);
        check_value("result messages", msg_count, 1);
        check_value("peeling seen", saw_peel, peel_table[c]);
        active = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        input_data = '0;
        input_valid = 1'b0;
        output_ready = 1'b0;
        ctrl_rx_data = '0;
        ctrl_rx_valid = 1'b0;
        busy_pe = '0;
        odd_clusters_pe = '0;
        correction = '0;
        rng = 32'hf3d7d0c3;
        cur = 0;
        active = 1'b0;
        word_taken = 1'b0;
        grows_seen = 0;
        merge_cycles = 0;
        merge_length = 0;
        result_index = 0;
        repeat (3) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;
        @(negedge clk);
        check_value("ctrl_rx_ready", ctrl_rx_ready, 1'b1);
        check_value("input_ready", input_ready, 1'b0);
        check_value("output_valid", output_valid, 1'b0);
        check_value("ctrl_tx_valid", ctrl_tx_valid, 1'b0);
        check_value("reset_all_edges", reset_all_edges, 1'b0);
        check_value("global_stage", global_stage, stage_idle);

        // initialize command passes through parameter loading
        @(posedge clk);
        #(drive_delay);
        ctrl_rx_data = '0;
        ctrl_rx_data[msg_header_msb:msg_header_lsb] = header_initialize_decoding;
        ctrl_rx_valid = 1'b1;
        @(posedge clk);
        #(drive_delay);
        ctrl_rx_valid = 1'b0;
        @(negedge clk);
        check_value("global_stage", global_stage, stage_parameters_loading);
        @(negedge clk);
        check_value("global_stage", global_stage, stage_idle);

        for (int c = 0; c < case_count; c++) begin
            run_case(c);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* tb/decoder_controller_sva.sv */
`timescale 1ns/10ps

module decoder_controller_sva
    import decoder_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       ctrl_rx_ready,
    input stage_t     global_stage,
    input data_word_t output_data,
    input logic       output_valid,
    input logic       output_ready,
    input logic       ctrl_tx_valid
);

    // host commands are taken only while idle
    assert property (@(posedge clk) disable iff (reset)
        ctrl_rx_ready |-> global_stage == stage_idle)
        else $error("ctrl_rx_ready high outside the idle stage");

    // stalled output word must hold
    assert property (@(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> output_valid && $stable(output_data))
        else $error("output word changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        ctrl_tx_valid |=> !ctrl_tx_valid)
        else $error("ctrl_tx_valid longer than one cycle");

endmodule

bind decoder_controller decoder_controller_sva u_sva (
    .clk           (clk),
    .reset         (reset),
    .ctrl_rx_ready (ctrl_rx_ready),
    .global_stage  (global_stage),
    .output_data   (output_data),
    .output_valid  (output_valid),
    .output_ready  (output_ready),
    .ctrl_tx_valid (ctrl_tx_valid)
);

/* source/decoder_controller.sv */
`timescale 1ns/10ps

module decoder_controller
    import decoder_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  data_word_t   input_data,
    input  logic         input_valid,
    output logic         input_ready,
    output data_word_t   output_data,
    output logic         output_valid,
    input  logic         output_ready,
    input  ctrl_word_t   ctrl_rx_data,
    input  logic         ctrl_rx_valid,
    output logic         ctrl_rx_ready,
    output ctrl_word_t   ctrl_tx_data,
    output logic         ctrl_tx_valid,
    input  pe_vector_t   busy_pe,
    input  pe_vector_t   odd_clusters_pe,
    output measurement_t measurements,
    input  correction_t  correction,
    output stage_t       global_stage,
    output logic         reset_all_edges
);

    logic load_advance;
    logic next_round_loaded;
    stats_word_t stats;

    stage_if sif ();

    stage_controller u_stage_controller (
        .clk               (clk),
        .reset             (reset),
        .ctrl_rx_data      (ctrl_rx_data),
        .ctrl_rx_valid     (ctrl_rx_valid),
        .ctrl_rx_ready     (ctrl_rx_ready),
        .busy_pe           (busy_pe),
        .odd_clusters_pe   (odd_clusters_pe),
        .load_advance      (load_advance),
        .next_round_loaded (next_round_loaded),
        .stats             (stats),
        .ctrl_tx_data      (ctrl_tx_data),
        .ctrl_tx_valid     (ctrl_tx_valid),
        .reset_all_edges   (reset_all_edges),
        .sif               (sif.ctrl)
    );

    measurement_loader u_measurement_loader (
        .clk               (clk),
        .reset             (reset),
        .input_data        (input_data),
        .input_valid       (input_valid),
        .input_ready       (input_ready),
        .measurements      (measurements),
        .load_advance      (load_advance),
        .next_round_loaded (next_round_loaded),
        .sif               (sif.loader)
    );

    decode_counters u_decode_counters (
        .clk   (clk),
        .reset (reset),
        .stats (stats),
        .sif   (sif.counters)
    );

    correction_encoder u_correction_encoder (
        .clk          (clk),
        .reset        (reset),
        .correction   (correction),
        .stats        (stats),
        .output_data  (output_data),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .sif          (sif.encoder)
    );

    // PE array follows the stage directly
    assign global_stage = sif.stage;

endmodule

/* source/correction_encoder.sv */
`timescale 1ns/10ps

module correction_encoder
    import decoder_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  correction_t correction,
    input  stats_word_t stats,
    output data_word_t  output_data,
    output logic        output_valid,
    input  logic        output_ready,
    stage_if.encoder    sif
);

    typedef enum logic [1:0] {
        enc_idle,
        enc_stats,
        enc_bits,
        enc_end
    } enc_state_t;

    enc_state_t state;
    correction_t fifo_mem [4];
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] fifo_count;
    logic push;
    logic pop;
    logic frame_start;
    logic frame_pending;
    stats_word_t stats_q;
    correction_t work;
    logic work_loaded;
    round_t out_round;
    logic [$clog2(correction_count)-1:0] bit_index;

    assign frame_start = (sif.stage == stage_result_valid) && (sif.round == '0);
    assign push = (sif.stage == stage_result_valid) && (fifo_count != 3'd4);
    assign pop = (state == enc_bits) && !work_loaded && (fifo_count != 3'd0);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= correction;
        end
        if (frame_start) begin
            stats_q <= stats;
        end
    end

    // lowest set bit goes out first
    always_comb begin
        bit_index = '0;
        for (int i = correction_count - 1; i >= 0; i--) begin
            if (work[i]) begin
                bit_index = ($clog2(correction_count))'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= enc_idle;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
            frame_pending <= 1'b0;
            work_loaded <= 1'b0;
            out_round <= '0;
        end else begin
            wr_ptr <= wr_ptr + push;
            rd_ptr <= rd_ptr + pop;
            fifo_count <= fifo_count + push - pop;
            if (frame_start) begin
                frame_pending <= 1'b1;
            end else if (state == enc_idle) begin
                frame_pending <= 1'b0;
            end
            case (state)
                enc_idle: begin
                    if (frame_pending) begin
                        state <= enc_stats;
                    end
                end
                enc_stats: begin
                    if (output_ready) begin
                        state <= enc_bits;
                        out_round <= '0;
                    end
                end
                enc_bits: begin
                    if (pop) begin
                        work <= fifo_mem[rd_ptr];
                        work_loaded <= 1'b1;
                    end else if (work_loaded && work == '0) begin
                        // round done, move on or close the frame
                        work_loaded <= 1'b0;
                        out_round <= out_round + 1'b1;
                        if (out_round == round_t'(grid_width_u - 1)) begin
                            state <= enc_end;
                        end
                    end else if (work_loaded && output_ready) begin
                        work[bit_index] <= 1'b0;
                    end
                end
                default: begin
                    if (output_ready) begin
                        state <= enc_idle;
                    end
                end
            endcase
        end
    end

    always_comb begin
        output_valid = 1'b0;
        output_data = '0;
        case (state)
            enc_stats: begin
                output_valid = 1'b1;
                output_data = stats_q;
            end
            enc_bits: begin
                output_valid = work_loaded && (work != '0);
                // {round, byte index, bit in byte}
                output_data = (data_word_t'(out_round) << (3 + $clog2(correction_bytes)))
                              | data_word_t'(bit_index);
            end
            enc_end: begin
                output_valid = 1'b1;
                output_data = end_of_stream_word;
            end
            default: begin
                output_valid = 1'b0;
            end
        endcase
    end

endmodule

/* source/decode_counters.sv */
`timescale 1ns/10ps

module decode_counters
    import decoder_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output stats_word_t stats,
    stage_if.counters   sif
);

    logic [15:0] cycle_count;
    logic [7:0] iteration_count;
    logic counting;

    // only the decoding work itself is timed
    assign counting = (sif.stage == stage_grow) || (sif.stage == stage_merge)
                      || (sif.stage == stage_peeling) || (sif.stage == stage_reset_roots);

    // starting at 1 makes the count include the accept cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else if (sif.decode_start) begin
            cycle_count <= 16'd1;
        end else if (counting) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_count <= '0;
        end else if (sif.stage == stage_measurement_loading) begin
            iteration_count <= '0;
        end else if (sif.grow_entry) begin
            iteration_count <= iteration_count + 1'b1;
        end
    end

    assign stats = {8'h00, iteration_count, cycle_count};

endmodule

/* source/measurement_loader.sv */
`timescale 1ns/10ps

module measurement_loader
    import decoder_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  data_word_t   input_data,
    input  logic         input_valid,
    output logic         input_ready,
    output measurement_t measurements,
    output logic         load_advance,
    output logic         next_round_loaded,
    stage_if.loader      sif
);

    round_t word_round;
    logic [x_bits-1:0] x_coord;
    logic [x_bits+z_bits-1:0] pu_address;
    logic round_match;
    measurement_t defects;

    // defect word is {round, x, z} from the low end
    assign x_coord = input_data[x_bits+z_bits-1:z_bits];
    assign pu_address = (x_bits + z_bits)'(x_coord * grid_width_z
                        + (input_data & ((32'd1 << z_bits) - 1)));

    // end marker counts as the round after the last one
    always_comb begin
        if (input_data == end_of_stream_word) begin
            word_round = round_t'(grid_width_u);
        end else begin
            word_round = {1'b0, input_data[u_bits+x_bits+z_bits-1:x_bits+z_bits]};
        end
    end

    assign round_match = (word_round == sif.round);
    assign load_advance = (sif.stage == stage_measurement_preparing) && input_valid && !round_match;
    assign next_round_loaded = input_valid && (word_round == round_t'(sif.round + 1'b1));

    // defects of the current round are taken, the marker only once all rounds are out
    always_comb begin
        input_ready = 1'b0;
        if (sif.stage == stage_measurement_preparing) begin
            input_ready = round_match;
        end else if (sif.stage == stage_measurement_loading) begin
            input_ready = (sif.round == round_t'(grid_width_u - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defects <= '0;
        end else if (sif.stage == stage_measurement_loading) begin
            defects <= '0;
        end else if (sif.stage == stage_measurement_preparing && input_valid && round_match) begin
            defects[pu_address] <= 1'b1;
        end
    end

    assign measurements = defects;

endmodule

/* source/stage_controller.sv */
`timescale 1ns/10ps

module stage_controller
    import decoder_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ctrl_word_t  ctrl_rx_data,
    input  logic        ctrl_rx_valid,
    output logic        ctrl_rx_ready,
    input  pe_vector_t  busy_pe,
    input  pe_vector_t  odd_clusters_pe,
    input  logic        load_advance,
    input  logic        next_round_loaded,
    input  stats_word_t stats,
    output ctrl_word_t  ctrl_tx_data,
    output logic        ctrl_tx_valid,
    output logic        reset_all_edges,
    stage_if.ctrl       sif
);

    logic [7:0] rx_header;
    logic busy_q;
    logic odd_q;
    logic peel_and_finish;
    logic roots_done;
    logic [$clog2(maximum_delay + 1)-1:0] delay_count;

    // array-wide status, one cycle behind the PEs
    always_ff @(posedge clk) begin
        busy_q <= |busy_pe;
        odd_q <= |odd_clusters_pe;
    end

    assign rx_header = ctrl_rx_data[msg_header_msb:msg_header_lsb];
    assign ctrl_rx_ready = (sif.stage == stage_idle);
    assign sif.decode_start = ctrl_rx_ready && ctrl_rx_valid && rx_header == header_decode_block;
    assign reset_all_edges = (sif.stage == stage_measurement_loading);

    always_ff @(posedge clk) begin
        if (reset) begin
            sif.stage <= stage_idle;
            sif.round <= '0;
            sif.grow_entry <= 1'b0;
            delay_count <= '0;
            peel_and_finish <= 1'b0;
            roots_done <= 1'b0;
        end else begin
            sif.grow_entry <= 1'b0;
            case (sif.stage)
                stage_idle: begin
                    if (ctrl_rx_valid && rx_header == header_initialize_decoding) begin
                        sif.stage <= stage_parameters_loading;
                    end else if (sif.decode_start) begin
                        sif.stage <= stage_measurement_preparing;
                        sif.round <= '0;
                        peel_and_finish <= ctrl_rx_data[0];
                        roots_done <= 1'b0;
                    end
                end
                stage_parameters_loading: begin
                    sif.stage <= stage_idle;
                end
                stage_measurement_preparing: begin
                    if (load_advance) begin
                        sif.stage <= stage_measurement_loading;
                    end
                end
                stage_measurement_loading: begin
                    if (sif.round == round_t'(grid_width_u - 1)) begin
                        sif.stage <= stage_grow;
                        sif.grow_entry <= 1'b1;
                        sif.round <= '0;
                    end else begin
                        sif.round <= sif.round + 1'b1;
                        // waiting word has defects for the next round
                        if (next_round_loaded) begin
                            sif.stage <= stage_measurement_preparing;
                        end
                    end
                end
                stage_grow: begin
                    sif.stage <= stage_merge;
                    delay_count <= '0;
                end
                stage_merge: begin
                    if (delay_count < maximum_delay) begin
                        delay_count <= delay_count + 1'b1;
                    end else if (!busy_q) begin
                        delay_count <= '0;
                        if (odd_q) begin
                            sif.stage <= stage_grow;
                            sif.grow_entry <= 1'b1;
                        end else if (!peel_and_finish) begin
                            sif.stage <= stage_result_valid;
                            sif.round <= '0;
                        end else if (!roots_done) begin
                            sif.stage <= stage_reset_roots;
                        end else begin
                            sif.stage <= stage_peeling;
                        end
                    end
                end
                stage_reset_roots: begin
                    sif.stage <= stage_merge;
                    roots_done <= 1'b1;
                    delay_count <= '0;
                end
                stage_peeling: begin
                    sif.stage <= stage_result_valid;
                    sif.round <= '0;
                end
                stage_result_valid: begin
                    if (sif.round == round_t'(grid_width_u - 1)) begin
                        sif.stage <= stage_idle;
                        sif.round <= '0;
                    end else begin
                        sif.round <= sif.round + 1'b1;
                    end
                end
                default: begin
                    sif.stage <= stage_idle;
                end
            endcase
        end
    end

    // result message goes to the host with the latency in cycles
    assign ctrl_tx_valid = (sif.stage == stage_result_valid) && (sif.round == '0);

    always_comb begin
        ctrl_tx_data = '0;
        ctrl_tx_data[msg_dest_msb:msg_dest_lsb] = 8'h00;
        ctrl_tx_data[msg_header_msb:msg_header_lsb] = header_result;
        ctrl_tx_data[15:0] = stats[15:0];
    end

endmodule

/* source/stage_if.sv */
`timescale 1ns/10ps

interface stage_if
    import decoder_pkg::*;
();

    stage_t stage;
    round_t round;
    logic decode_start;
    logic grow_entry;

    modport ctrl (output stage, output round, output decode_start, output grow_entry);
    modport loader (input stage, input round);
    modport counters (input stage, input decode_start, input grow_entry);
    modport encoder (input stage, input round);

endinterface

/* source/decoder_pkg.sv */
package decoder_pkg;

    // grid of processing elements
    localparam int grid_width_x = 4;
    localparam int grid_width_z = 1;
    localparam int grid_width_u = 3;
    localparam int pu_count_per_round = grid_width_x * grid_width_z;
    localparam int pu_count = pu_count_per_round * grid_width_u;

    // ns + ew + ud edges of one round, padded to whole bytes on output
    localparam int correction_count = 11;
    localparam int correction_bytes = 2;
    localparam int maximum_delay = 3;

    localparam int x_bits = $clog2(grid_width_x);
    localparam int z_bits = $clog2(grid_width_z);
    localparam int u_bits = $clog2(grid_width_u);

    // control message layout
    localparam int msg_dest_msb = 63;
    localparam int msg_dest_lsb = 56;
    localparam int msg_header_msb = 55;
    localparam int msg_header_lsb = 48;

    localparam logic [7:0] header_initialize_decoding = 8'h00;
    localparam logic [7:0] header_decode_block = 8'h01;
    localparam logic [7:0] header_result = 8'h02;
    localparam logic [31:0] end_of_stream_word = 32'hffff_ffff;

    typedef enum logic [3:0] {
        stage_idle = 4'd0,
        stage_grow = 4'd2,
        stage_merge = 4'd3,
        stage_peeling = 4'd4,
        stage_result_valid = 4'd5,
        stage_parameters_loading = 4'd6,
        stage_measurement_preparing = 4'd7,
        stage_reset_roots = 4'd8,
        stage_measurement_loading = 4'd9
    } stage_t;

    // one spare bit so the end marker can count as round grid_width_u
    typedef logic [u_bits:0] round_t;
    typedef logic [pu_count_per_round-1:0] measurement_t;
    typedef logic [pu_count-1:0] pe_vector_t;
    typedef logic [correction_count-1:0] correction_t;
    typedef logic [63:0] ctrl_word_t;
    typedef logic [31:0] data_word_t;
    typedef logic [31:0] stats_word_t;

endpackage
